/* logic/config_target_pkg.sv */
package config_target_pkg;

  // Bus widths
  localparam int CFG_BUS_ADDR_W = 32;
  localparam int CFG_BUS_DATA_W = 32;

  // Slave address map, one 256-byte window per slave
  localparam logic [CFG_BUS_ADDR_W-1:0] CFG_PRCI_BASE  = 32'h0000_0000;
  localparam logic [CFG_BUS_ADDR_W-1:0] CFG_GPIO_BASE  = 32'h0000_0100;
  localparam logic [CFG_BUS_ADDR_W-1:0] CFG_DDR_BASE   = 32'h0000_0200;
  localparam logic [CFG_BUS_ADDR_W-1:0] CFG_SLAVE_SIZE = 32'h0000_0100;

  // Offset bits decoded inside a slave window
  localparam int CFG_REG_OFFS_W = $clog2(CFG_SLAVE_SIZE);

  // PRCI registers
  localparam logic [CFG_REG_OFFS_W-1:0] REG_STATUS     = 8'h00;
  localparam logic [CFG_REG_OFFS_W-1:0] REG_CTRL       = 8'h04;
  // GPIO registers
  localparam logic [CFG_REG_OFFS_W-1:0] REG_GPIO_IN    = 8'h00;
  localparam logic [CFG_REG_OFFS_W-1:0] REG_GPIO_OUT   = 8'h04;
  localparam logic [CFG_REG_OFFS_W-1:0] REG_GPIO_DIR   = 8'h08;
  // DDR controller registers
  localparam logic [CFG_REG_OFFS_W-1:0] REG_DDR_STATUS = 8'h00;
  localparam logic [CFG_REG_OFFS_W-1:0] REG_DDR_CYCLES = 8'h04;

endpackage

/* logic/types_amba_pkg.sv */
package types_amba_pkg;
  import config_target_pkg::*;

  // APB request from master to slave
  typedef struct packed {
    logic                      pselx;
    logic                      penable;
    logic                      pwrite;
    logic [CFG_BUS_ADDR_W-1:0] paddr;
    logic [CFG_BUS_DATA_W-1:0] pwdata;
  } apb_in_type;

  // APB response from slave to master
  typedef struct packed {
    logic                      pready;
    logic [CFG_BUS_DATA_W-1:0] prdata;
    logic                      pslverr;
  } apb_out_type;

  // Idle response
  localparam apb_out_type apb_out_none = '{
    pready:  1'b0,
    prdata:  '0,
    pslverr: 1'b0
  };

  // One slave region in the address map, size in bytes
  typedef struct packed {
    logic [CFG_BUS_ADDR_W-1:0] base;
    logic [CFG_BUS_ADDR_W-1:0] size;
  } mapinfo_type;

endpackage

/* logic/apb_prci.sv */
`timescale 1ns/1ps

module apb_prci
  import types_amba_pkg::*;
  import config_target_pkg::*;
#(
  parameter int RST_HOLD_CYCLES = 8
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  apb_in_type  i_apbi,
  output apb_out_type o_apbo,
  input  logic        i_ddr_calib_done,
  output logic        o_sys_nrst,
  output logic        o_dbg_nrst,
  output logic        o_ddr_nrst
);

  localparam int CNT_W = $clog2(RST_HOLD_CYCLES + 1);

  // Reset sequencer states
  typedef enum logic [1:0] {
    ST_DDR_HOLD,
    ST_CALIB,
    ST_RUN,
    ST_SW_HOLD
  } state_e;

  state_e                    state;
  logic [CNT_W-1:0]          hold_cnt;
  logic                      hold_done;
  logic [CFG_REG_OFFS_W-1:0] reg_offs;
  logic                      wr_en;
  logic                      sw_rst;

  assign reg_offs  = i_apbi.paddr[CFG_REG_OFFS_W-1:0];
  assign wr_en     = i_apbi.pselx & i_apbi.penable & i_apbi.pwrite;
  // Write-one pulse on CTRL bit 0
  assign sw_rst    = wr_en && (reg_offs == REG_CTRL) && i_apbi.pwdata[0];
  assign hold_done = (hold_cnt == CNT_W'(RST_HOLD_CYCLES - 1));

  // One hold counter serves both the power-on and the software reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_DDR_HOLD;
      hold_cnt <= '0;
    end else begin
      case (state)
        ST_DDR_HOLD: begin
          if (hold_done) begin
            state    <= ST_CALIB;
            hold_cnt <= '0;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        ST_CALIB: begin
          if (i_ddr_calib_done) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (sw_rst) begin
            state    <= ST_SW_HOLD;
            hold_cnt <= '0;
          end
        end
        ST_SW_HOLD: begin
          if (hold_done) begin
            state    <= ST_RUN;
            hold_cnt <= '0;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: begin
          state <= ST_DDR_HOLD;
        end
      endcase
    end
  end

  // Reset outputs decoded from the sequencer state
  assign o_ddr_nrst = (state != ST_DDR_HOLD);
  assign o_sys_nrst = (state == ST_RUN);
  // Debug domain survives a software system reset
  assign o_dbg_nrst = (state == ST_RUN) || (state == ST_SW_HOLD);

  // Zero wait-state register read
  always_comb begin
    o_apbo        = apb_out_none;
    o_apbo.pready = i_apbi.pselx & i_apbi.penable;
    case (reg_offs)
      REG_STATUS: o_apbo.prdata[2:0] = {i_ddr_calib_done, o_ddr_nrst, o_sys_nrst};
      default:    o_apbo.prdata      = '0;
    endcase
  end

endmodule

/* logic/apb_gpio.sv */
`timescale 1ns/1ps

module apb_gpio
  import types_amba_pkg::*;
  import config_target_pkg::*;
#(
  parameter int GPIO_WIDTH = 12
) (
  input  logic                  i_clk,
  input  logic                  i_sys_nrst,
  input  apb_in_type            i_apbi,
  output apb_out_type           o_apbo,
  input  logic [GPIO_WIDTH-1:0] i_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_dir
);

  logic [GPIO_WIDTH-1:0]     r_out;
  logic [GPIO_WIDTH-1:0]     r_dir;
  logic [GPIO_WIDTH-1:0]     r_in;
  logic [CFG_REG_OFFS_W-1:0] reg_offs;
  logic                      wr_en;

  assign reg_offs = i_apbi.paddr[CFG_REG_OFFS_W-1:0];
  assign wr_en    = i_apbi.pselx & i_apbi.penable & i_apbi.pwrite;

  always_ff @(posedge i_clk) begin
    if (!i_sys_nrst) begin
      r_out <= '0;
      r_dir <= '0;
      r_in  <= '0;
    end else begin
      // Input pins sampled every cycle
      r_in <= i_gpio;
      if (wr_en) begin
        // Upper write data bits are dropped
        case (reg_offs)
          REG_GPIO_OUT: r_out <= i_apbi.pwdata[GPIO_WIDTH-1:0];
          REG_GPIO_DIR: r_dir <= i_apbi.pwdata[GPIO_WIDTH-1:0];
          default: begin
          end
        endcase
      end
    end
  end

  assign o_gpio     = r_out;
  assign o_gpio_dir = r_dir;

  always_comb begin
    o_apbo        = apb_out_none;
    o_apbo.pready = i_apbi.pselx & i_apbi.penable;
    case (reg_offs)
      REG_GPIO_IN:  o_apbo.prdata = CFG_BUS_DATA_W'(r_in);
      REG_GPIO_OUT: o_apbo.prdata = CFG_BUS_DATA_W'(r_out);
      REG_GPIO_DIR: o_apbo.prdata = CFG_BUS_DATA_W'(r_dir);
      default:      o_apbo.prdata = '0;
    endcase
  end

endmodule

/* logic/apb_ddr_ctrl.sv */
`timescale 1ns/1ps

module apb_ddr_ctrl
  import types_amba_pkg::*;
  import config_target_pkg::*;
#(
  parameter int CALIB_CYCLES = 20
) (
  input  logic        i_clk,
  input  logic        i_ddr_nrst,
  input  logic        i_sys_nrst,
  input  apb_in_type  i_apbi,
  output apb_out_type o_apbo,
  output logic        o_calib_done
);

  localparam int CNT_W = $clog2(CALIB_CYCLES + 1);

  logic [CNT_W-1:0]          calib_cnt;
  logic                      calib_done;
  logic                      r_status;
  logic [CNT_W-1:0]          r_cycles;
  logic [CFG_REG_OFFS_W-1:0] reg_offs;

  assign reg_offs = i_apbi.paddr[CFG_REG_OFFS_W-1:0];

  // Calibration model: count from DDR reset release, then hold
  always_ff @(posedge i_clk) begin
    if (!i_ddr_nrst) begin
      calib_cnt  <= '0;
      calib_done <= 1'b0;
    end else if (!calib_done) begin
      calib_cnt <= calib_cnt + 1'b1;
      if (calib_cnt == CNT_W'(CALIB_CYCLES - 1)) begin
        calib_done <= 1'b1;
      end
    end
  end

  assign o_calib_done = calib_done;

  // Status copies live in the system domain
  always_ff @(posedge i_clk) begin
    if (!i_sys_nrst) begin
      r_status <= 1'b0;
      r_cycles <= '0;
    end else begin
      r_status <= calib_done;
      if (calib_done) begin
        r_cycles <= calib_cnt;
      end
    end
  end

  // Both registers are read-only
  always_comb begin
    o_apbo        = apb_out_none;
    o_apbo.pready = i_apbi.pselx & i_apbi.penable;
    case (reg_offs)
      REG_DDR_STATUS: o_apbo.prdata[0] = r_status;
      REG_DDR_CYCLES: o_apbo.prdata    = CFG_BUS_DATA_W'(r_cycles);
      default:        o_apbo.prdata    = '0;
    endcase
  end

endmodule

/* logic/apb_bus_decoder.sv */
`timescale 1ns/1ps

module apb_bus_decoder
  import types_amba_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  apb_in_type  i_apbi,
  output apb_out_type o_apbo,
  input  mapinfo_type i_prci_map,
  input  mapinfo_type i_gpio_map,
  input  mapinfo_type i_ddr_map,
  output apb_in_type  o_prci_apbi,
  output apb_in_type  o_gpio_apbi,
  output apb_in_type  o_ddr_apbi,
  input  apb_out_type i_prci_apbo,
  input  apb_out_type i_gpio_apbo,
  input  apb_out_type i_ddr_apbo
);

  typedef enum logic [1:0] {
    SLV_NONE,
    SLV_PRCI,
    SLV_GPIO,
    SLV_DDR
  } slv_e;

  logic hit_prci;
  logic hit_gpio;
  logic hit_ddr;
  slv_e sel_now;
  slv_e r_sel;

  function automatic logic in_region(input apb_in_type apbi, input mapinfo_type map);
    return (apbi.paddr >= map.base) && (apbi.paddr < (map.base + map.size));
  endfunction

  assign hit_prci = in_region(i_apbi, i_prci_map);
  assign hit_gpio = in_region(i_apbi, i_gpio_map);
  assign hit_ddr  = in_region(i_apbi, i_ddr_map);

  always_comb begin
    if (hit_prci) begin
      sel_now = SLV_PRCI;
    end else if (hit_gpio) begin
      sel_now = SLV_GPIO;
    end else if (hit_ddr) begin
      sel_now = SLV_DDR;
    end else begin
      sel_now = SLV_NONE;
    end
  end

  // Slave choice is captured in the setup cycle and held while the address is stable
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_sel <= SLV_NONE;
    end else if (i_apbi.pselx && !i_apbi.penable) begin
      r_sel <= sel_now;
    end
  end

  always_comb begin
    o_prci_apbi       = i_apbi;
    o_gpio_apbi       = i_apbi;
    o_ddr_apbi        = i_apbi;
    o_prci_apbi.pselx = i_apbi.pselx & (sel_now == SLV_PRCI);
    o_gpio_apbi.pselx = i_apbi.pselx & (sel_now == SLV_GPIO);
    o_ddr_apbi.pselx  = i_apbi.pselx & (sel_now == SLV_DDR);
  end

  // Response mux that answers a miss with an error
  always_comb begin
    o_apbo = apb_out_none;
    if (i_apbi.pselx && i_apbi.penable) begin
      case (r_sel)
        SLV_PRCI: o_apbo = i_prci_apbo;
        SLV_GPIO: o_apbo = i_gpio_apbo;
        SLV_DDR:  o_apbo = i_ddr_apbo;
        default: begin
          o_apbo.pready  = 1'b1;
          o_apbo.pslverr = 1'b1;
        end
      endcase
    end
  end

endmodule

/* logic/board_top.sv */
`timescale 1ns/1ps

module board_top
  import types_amba_pkg::*;
  import config_target_pkg::*;
#(
  parameter int GPIO_WIDTH      = 12,
  parameter int RST_HOLD_CYCLES = 8,
  parameter int CALIB_CYCLES    = 20
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  apb_in_type            i_apbi,
  output apb_out_type           o_apbo,
  input  logic [GPIO_WIDTH-1:0] i_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_dir,
  output logic                  o_sys_nrst,
  output logic                  o_ddr_init_calib_complete
);

  // Address map records
  mapinfo_type prci_pmapinfo;
  mapinfo_type gpio_pmapinfo;
  mapinfo_type ddr_pmapinfo;

  apb_in_type  prci_apbi;
  apb_out_type prci_apbo;
  apb_in_type  gpio_apbi;
  apb_out_type gpio_apbo;
  apb_in_type  ddr_apbi;
  apb_out_type ddr_apbo;

  logic w_sys_nrst;
  logic w_ddr_nrst;
  logic w_ddr_calib_done;

  assign prci_pmapinfo = '{base: CFG_PRCI_BASE, size: CFG_SLAVE_SIZE};
  assign gpio_pmapinfo = '{base: CFG_GPIO_BASE, size: CFG_SLAVE_SIZE};
  assign ddr_pmapinfo  = '{base: CFG_DDR_BASE,  size: CFG_SLAVE_SIZE};

  assign o_sys_nrst                = w_sys_nrst;
  assign o_ddr_init_calib_complete = w_ddr_calib_done;

  apb_bus_decoder bus0 (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_apbi(i_apbi),
    .o_apbo(o_apbo),
    .i_prci_map(prci_pmapinfo),
    .i_gpio_map(gpio_pmapinfo),
    .i_ddr_map(ddr_pmapinfo),
    .o_prci_apbi(prci_apbi),
    .o_gpio_apbi(gpio_apbi),
    .o_ddr_apbi(ddr_apbi),
    .i_prci_apbo(prci_apbo),
    .i_gpio_apbo(gpio_apbo),
    .i_ddr_apbo(ddr_apbo)
  );

  // PLL and reset control
  apb_prci #(
    .RST_HOLD_CYCLES(RST_HOLD_CYCLES)
  ) prci0 (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_apbi(prci_apbi),
    .o_apbo(prci_apbo),
    .i_ddr_calib_done(w_ddr_calib_done),
    .o_sys_nrst(w_sys_nrst),
    .o_dbg_nrst(),  // no debug module on this board model
    .o_ddr_nrst(w_ddr_nrst)
  );

  apb_gpio #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) gpio0 (
    .i_clk(i_clk),
    .i_sys_nrst(w_sys_nrst),
    .i_apbi(gpio_apbi),
    .o_apbo(gpio_apbo),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir)
  );

  apb_ddr_ctrl #(
    .CALIB_CYCLES(CALIB_CYCLES)
  ) ddr0 (
    .i_clk(i_clk),
    .i_ddr_nrst(w_ddr_nrst),
    .i_sys_nrst(w_sys_nrst),
    .i_apbi(ddr_apbi),
    .o_apbo(ddr_apbo),
    .o_calib_done(w_ddr_calib_done)
  );

endmodule

/* verif/board_top_properties.sv */
`timescale 1ns/1ps

module board_top_properties
  import types_amba_pkg::*;
#(
  parameter int GPIO_WIDTH = 12
) (
  input logic                  i_clk,
  input logic                  i_rst,
  input apb_in_type            i_apbi,
  input apb_out_type           i_apbo,
  input logic [GPIO_WIDTH-1:0] i_gpio_out,
  input logic                  i_sys_nrst,
  input logic                  i_calib_done
);

  // Zero wait states put ready in every access cycle and nowhere else
  ready_in_access: assert property (@(posedge i_clk) disable iff (i_rst)
    i_apbo.pready == (i_apbi.pselx && i_apbi.penable))
    else $error("APB ready missing in an access cycle or seen outside one");

  // GPIO register clears on the edge after the system reset drops
  gpio_clear_in_reset: assert property (@(posedge i_clk) disable iff (i_rst)
    !i_sys_nrst |=> (i_gpio_out == '0))
    else $error("GPIO output not cleared during system reset");

  sys_after_calib: assert property (@(posedge i_clk) disable iff (i_rst)
    i_sys_nrst |-> i_calib_done)
    else $error("System reset released before DDR calibration");

endmodule

bind board_top board_top_properties #(
  .GPIO_WIDTH(GPIO_WIDTH)
) props (
  .i_clk(i_clk),
  .i_rst(i_rst),
  .i_apbi(i_apbi),
  .i_apbo(o_apbo),
  .i_gpio_out(o_gpio),
  .i_sys_nrst(o_sys_nrst),
  .i_calib_done(o_ddr_init_calib_complete)
);

/* verif/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top
  import types_amba_pkg::*;
  import config_target_pkg::*;
;

  localparam int CLK_PERIOD      = 40;
  localparam int GPIO_WIDTH      = 12;
  localparam int RST_HOLD_CYCLES = 8;
  localparam int CALIB_CYCLES    = 20;
  localparam int WAIT_LIMIT      = 200;
  localparam int NUM_ENTRIES     = 20;
  localparam int BOOT_ENTRIES    = 15;

  localparam logic [31:0] GPIO_MASK        = (32'd1 << GPIO_WIDTH) - 32'd1;
  localparam logic [31:0] PRCI_STATUS_ADDR = CFG_PRCI_BASE | 32'(REG_STATUS);
  localparam logic [31:0] PRCI_CTRL_ADDR   = CFG_PRCI_BASE | 32'(REG_CTRL);
  localparam logic [31:0] GPIO_IN_ADDR     = CFG_GPIO_BASE | 32'(REG_GPIO_IN);
  localparam logic [31:0] GPIO_OUT_ADDR    = CFG_GPIO_BASE | 32'(REG_GPIO_OUT);
  localparam logic [31:0] GPIO_DIR_ADDR    = CFG_GPIO_BASE | 32'(REG_GPIO_DIR);
  localparam logic [31:0] DDR_STATUS_ADDR  = CFG_DDR_BASE | 32'(REG_DDR_STATUS);
  localparam logic [31:0] DDR_CYCLES_ADDR  = CFG_DDR_BASE | 32'(REG_DDR_CYCLES);
  localparam logic [31:0] UNMAPPED_ADDR    = 32'h0000_0300;

  // One APB transfer with its expected response
  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic        exp_err;
  } entry_t;

  logic                  clk = 1'b0;
  logic                  rst;
  apb_in_type            apbi;
  apb_out_type           apbo;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_dir;
  logic                  sys_nrst;
  logic                  calib_done;

  entry_t      stim_table [NUM_ENTRIES];
  logic [31:0] lcg_state;
  logic [31:0] out_val;
  logic [31:0] dir_val;
  logic [31:0] rnd;
  logic [31:0] rdata;
  logic        slverr;
  int          checks;
  int          errors;
  int          timeouts;

  board_top #(
    .GPIO_WIDTH(GPIO_WIDTH),
    .RST_HOLD_CYCLES(RST_HOLD_CYCLES),
    .CALIB_CYCLES(CALIB_CYCLES)
  ) DUT (
    .i_clk(clk),
    .i_rst(rst),
    .i_apbi(apbi),
    .o_apbo(apbo),
    .i_gpio(gpio_in),
    .o_gpio(gpio_out),
    .o_gpio_dir(gpio_dir),
    .o_sys_nrst(sys_nrst),
    .o_ddr_init_calib_complete(calib_done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic entry_t make_entry(input logic is_write, input logic [31:0] addr,
                                        input logic [31:0] wdata, input logic [31:0] exp_data,
                                        input logic exp_err);
    return '{is_write: is_write, addr: addr, wdata: wdata, exp_data: exp_data, exp_err: exp_err};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  // Setup and access phases, each started on a falling edge
  task automatic apb_access(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] data,
                            output logic err);
    int waited;
    waited = 0;
    data = '0;
    err = 1'b0;
    @(negedge clk);
    apbi = '{pselx: 1'b1, penable: 1'b0, pwrite: is_write, paddr: addr, pwdata: wdata};
    @(negedge clk);
    apbi.penable = 1'b1;
    #(CLK_PERIOD / 4);
    while (!apbo.pready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      waited++;
    end
    if (apbo.pready) begin
      data = apbo.prdata;
      err = apbo.pslverr;
    end else begin
      $display("Timeout: no APB ready from address 0x%08h", addr);
      timeouts++;
    end
    @(negedge clk);
    apbi = '0;
  endtask

  task automatic wait_reset_sequence();
    int cycles;
    cycles = 0;
    while (!calib_done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!calib_done) begin
      $display("Timeout: DDR calibration never completed after reset");
      timeouts++;
    end else begin
      check_value("calib cycles after reset", 32'(cycles),
                  32'(RST_HOLD_CYCLES + CALIB_CYCLES));
      check_value("o_sys_nrst", 32'(sys_nrst), 32'd0);
      @(negedge clk);
      check_value("o_sys_nrst", 32'(sys_nrst), 32'd1);
    end
  endtask

  task automatic wait_sys_release();
    int low_cycles;
    low_cycles = 0;
    while (!sys_nrst && low_cycles < WAIT_LIMIT) begin
      @(negedge clk);
      low_cycles++;
    end
    if (!sys_nrst) begin
      $display("Timeout: system reset stayed low after the software reset");
      timeouts++;
    end else begin
      check_value("sys reset low cycles", 32'(low_cycles), 32'(RST_HOLD_CYCLES));
    end
  endtask

  task automatic apply_entries(input int first, input int last);
    int i;
    entry_t e;
    logic [31:0] data;
    logic err;
    for (i = first; i <= last; i++) begin
      e = stim_table[i];
      apb_access(e.is_write, e.addr, e.wdata, data, err);
      check_value($sformatf("pslverr @0x%03h", e.addr), 32'(err), 32'(e.exp_err));
      if (!e.is_write) begin
        check_value($sformatf("prdata @0x%03h", e.addr), data, e.exp_data);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    apbi = '0;
    gpio_in = '0;
    checks = 0;
    errors = 0;
    timeouts = 0;
    lcg_state = 32'd62;
    out_val = next_random();
    dir_val = next_random();
    rnd = next_random();
    gpio_in = rnd[GPIO_WIDTH-1:0];
    rnd = next_random();

    // After boot
    stim_table[0]  = make_entry(1'b0, PRCI_STATUS_ADDR, '0, 32'h7, 1'b0);
    stim_table[1]  = make_entry(1'b0, DDR_STATUS_ADDR, '0, 32'h1, 1'b0);
    stim_table[2]  = make_entry(1'b0, DDR_CYCLES_ADDR, '0, 32'(CALIB_CYCLES), 1'b0);
    stim_table[3]  = make_entry(1'b1, GPIO_OUT_ADDR, out_val, '0, 1'b0);
    stim_table[4]  = make_entry(1'b0, GPIO_OUT_ADDR, '0, out_val & GPIO_MASK, 1'b0);
    stim_table[5]  = make_entry(1'b1, GPIO_DIR_ADDR, dir_val, '0, 1'b0);
    stim_table[6]  = make_entry(1'b0, GPIO_DIR_ADDR, '0, dir_val & GPIO_MASK, 1'b0);
    stim_table[7]  = make_entry(1'b0, UNMAPPED_ADDR, '0, '0, 1'b1);
    stim_table[8]  = make_entry(1'b1, UNMAPPED_ADDR, rnd, '0, 1'b1);
    // Read-only registers ignore writes
    stim_table[9]  = make_entry(1'b1, PRCI_STATUS_ADDR, 32'h1, '0, 1'b0);
    stim_table[10] = make_entry(1'b0, PRCI_STATUS_ADDR, '0, 32'h7, 1'b0);
    stim_table[11] = make_entry(1'b1, DDR_CYCLES_ADDR, rnd, '0, 1'b0);
    stim_table[12] = make_entry(1'b0, DDR_CYCLES_ADDR, '0, 32'(CALIB_CYCLES), 1'b0);
    stim_table[13] = make_entry(1'b1, GPIO_IN_ADDR, rnd, '0, 1'b0);
    stim_table[14] = make_entry(1'b0, GPIO_IN_ADDR, '0, 32'(gpio_in), 1'b0);
    // After the software system reset
    stim_table[15] = make_entry(1'b0, GPIO_OUT_ADDR, '0, '0, 1'b0);
    stim_table[16] = make_entry(1'b0, GPIO_DIR_ADDR, '0, '0, 1'b0);
    stim_table[17] = make_entry(1'b0, PRCI_STATUS_ADDR, '0, 32'h7, 1'b0);
    stim_table[18] = make_entry(1'b0, DDR_STATUS_ADDR, '0, 32'h1, 1'b0);
    stim_table[19] = make_entry(1'b0, DDR_CYCLES_ADDR, '0, 32'(CALIB_CYCLES), 1'b0);

    repeat (3) @(negedge clk);
    rst = 1'b0;
    wait_reset_sequence();
    apply_entries(0, BOOT_ENTRIES - 1);
    check_value("o_gpio", 32'(gpio_out), out_val & GPIO_MASK);
    check_value("o_gpio_dir", 32'(gpio_dir), dir_val & GPIO_MASK);

    apb_access(1'b1, PRCI_CTRL_ADDR, 32'h1, rdata, slverr);
    check_value("pslverr @PRCI ctrl", 32'(slverr), 32'd0);
    check_value("o_sys_nrst", 32'(sys_nrst), 32'd0);
    check_value("o_ddr_init_calib_complete", 32'(calib_done), 32'd1);
    wait_sys_release();
    check_value("o_gpio", 32'(gpio_out), 32'd0);
    check_value("o_gpio_dir", 32'(gpio_dir), 32'd0);
    check_value("o_ddr_init_calib_complete", 32'(calib_done), 32'd1);
    apply_entries(BOOT_ENTRIES, NUM_ENTRIES - 1);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
logic/config_target_pkg.sv
logic/types_amba_pkg.sv
logic/apb_prci.sv
logic/apb_gpio.sv
logic/apb_ddr_ctrl.sv
logic/apb_bus_decoder.sv
logic/board_top.sv
verif/board_top_properties.sv
verif/tb_board_top.sv

/* Makefile */
SRCS = $(wildcard logic/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_board_top: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_board_top -f filelist.f

run: obj_dir/Vtb_board_top
	obj_dir/Vtb_board_top > sim.log 2>&1 || true
	@cat sim.log
	@! grep -q "Testbench failed" sim.log
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
